// ==== common/fix_pkg.sv ====
// --------------------------------------------------------------------------
// FIX 4.2 subset only, ids at most 8 bytes, sequence numbers below 1000
// checksum and sequence values are rendered as three ASCII digits
// --------------------------------------------------------------------------
package fix_pkg;

	localparam logic [7:0] SOH      = 8'h01;	// field delimiter
	localparam logic [7:0] ASCII_EQ = 8'h3D;	// '='
	localparam logic [7:0] ASCII_0  = 8'h30;	// '0'

	localparam int MAX_VALUE_BYTES = 8;		// later bytes dropped, still counted

	localparam logic [13:0] TAG_BEGIN  = 14'd8;
	localparam logic [13:0] TAG_SEQ    = 14'd34;
	localparam logic [13:0] TAG_TYPE   = 14'd35;
	localparam logic [13:0] TAG_SENDER = 14'd49;
	localparam logic [13:0] TAG_TARGET = 14'd56;
	localparam logic [13:0] TAG_CSUM   = 14'd10;

	localparam logic [7:0] MSG_LOGON     = 8'h41;	// 'A'
	localparam logic [7:0] MSG_HEARTBEAT = 8'h30;	// '0'
	localparam logic [7:0] MSG_TEST_REQ  = 8'h31;	// '1'
	localparam logic [7:0] MSG_LOGOUT    = 8'h35;	// '5'

	// one-hot so a corrupted state is detectable
	typedef enum logic [1:0] {
		DISCONNECTED = 2'b01,
		LOGGED_ON    = 2'b10
	} fix_sess_state_e;

	// decoder -> session ctrl, one cycle pulse per field
	typedef struct packed {
		logic [13:0] tag;		// binary tag number
		logic [63:0] value;		// ascii, left aligned
		logic [3:0]  value_len;		// saturates at 15, >8 means truncated
		logic        is_last;		// tag 10 field
		logic        csum_ok;		// only meaningful with is_last
		logic        valid;
	} fix_field_t;

	// session ctrl -> reply builder, held until req_ready
	typedef struct packed {
		logic [7:0]  msg_type;		// ascii type char
		logic [9:0]  seq_num;		// outbound seq, binary
		logic [63:0] target_id;		// ascii, left aligned
		logic [3:0]  target_len;	// 0..8
		logic        valid;
	} fix_reply_req_t;

	// binary to three ascii digits, hundreds first
	function automatic logic [23:0] to_dec3(input logic [13:0] n);
		logic [13:0] h;
		logic [13:0] t;
		logic [13:0] o;
		h = (n / 14'd100) % 14'd10;
		t = (n / 14'd10) % 14'd10;
		o = n % 14'd10;
		return {ASCII_0 + h[7:0], ASCII_0 + t[7:0], ASCII_0 + o[7:0]};
	endfunction

endpackage

// ==== fix_decode/fix_field_decoder.sv ====
// --------------------------------------------------------------------------
// takes one byte per valid cycle, no back-pressure on rx
// checksum restarts at every "8=", only the first 8 value bytes are kept
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fix_field_decoder (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic [7:0]          rx_byte_i,
	input  logic                rx_valid_i,
	output fix_pkg::fix_field_t field_o
);

	// sum of "8=" already consumed when tag 8 is recognised
	localparam logic [7:0] BEGIN_SUM = 8'h38 + fix_pkg::ASCII_EQ;

	logic                in_value_q;	// 0 tag phase, 1 value phase
	logic [13:0]         tag_q;		// tag digits so far
	logic [63:0]         val_q;		// value bytes, left aligned
	logic [3:0]          len_q;		// value byte count
	logic [9:0]          num_q;		// value read as decimal
	logic [7:0]          csum_q;		// running sum mod 256
	logic [7:0]          mark_q;		// sum through last SOH
	logic                is_digit;
	logic                is_csum;
	fix_pkg::fix_field_t field_q;

	assign is_digit = (rx_byte_i >= 8'h30) && (rx_byte_i <= 8'h39);
	assign is_csum  = (tag_q == fix_pkg::TAG_CSUM);
	assign field_o  = field_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_value_q <= 1'b0;
			tag_q      <= '0;
			val_q      <= '0;
			len_q      <= '0;
			num_q      <= '0;
			csum_q     <= '0;
			mark_q     <= '0;
			field_q    <= '0;
		end else begin
			field_q.valid   <= 1'b0;	// pulse only
			field_q.is_last <= 1'b0;
			field_q.csum_ok <= 1'b0;
			if (rx_valid_i) begin
				csum_q <= csum_q + rx_byte_i;
				if (!in_value_q) begin
					if (rx_byte_i == fix_pkg::ASCII_EQ) begin
						in_value_q <= 1'b1;
						if (tag_q == fix_pkg::TAG_BEGIN) begin
							csum_q <= BEGIN_SUM;	// new message
						end
					end else if (is_digit) begin
						tag_q <= tag_q * 14'd10 + {10'b0, rx_byte_i[3:0]};
					end else begin
						tag_q <= '0;	// stray byte, restart tag
					end
				end else if (rx_byte_i == fix_pkg::SOH) begin
					in_value_q <= 1'b0;
					tag_q      <= '0;
					val_q      <= '0;
					len_q      <= '0;
					num_q      <= '0;
					mark_q     <= csum_q + rx_byte_i;	// includes this SOH
					field_q.tag       <= tag_q;
					field_q.value     <= val_q;
					field_q.value_len <= len_q;
					field_q.is_last   <= is_csum;
					// old mark_q is the sum up to the SOH before "10="
					field_q.csum_ok   <= is_csum && (num_q == {2'b00, mark_q});
					field_q.valid     <= 1'b1;
				end else begin
					if (len_q < 4'(fix_pkg::MAX_VALUE_BYTES)) begin
						val_q[63 - 8*len_q -: 8] <= rx_byte_i;
					end
					if (len_q != 4'hf) begin
						len_q <= len_q + 4'd1;	// saturating
					end
					num_q <= num_q * 10'd10 + {6'b0, rx_byte_i[3:0]};
				end
			end
		end
	end

	// csum_ok must ride on a real checksum field pulse
	a_csum_on_last: assert property (@(posedge clk) disable iff (!rst_n_i)
		field_o.csum_ok |-> field_o.valid && field_o.is_last &&
			(field_o.tag == fix_pkg::TAG_CSUM));

endmodule

// ==== fix_session/fix_session_ctrl.sv ====
// --------------------------------------------------------------------------
// single pending reply, decisions made while it is still held are dropped
// no resend or gap fill, a sequence mismatch always ends the session
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fix_session_ctrl #(
	parameter int unsigned HB_INTERVAL = 1000	// idle cycles before heartbeat
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  fix_pkg::fix_field_t     field_i,
	output fix_pkg::fix_reply_req_t req_o,
	input  logic                    req_ready_i,
	output logic                    session_up_o
);

	localparam int HB_W = $clog2(HB_INTERVAL + 1);

	fix_pkg::fix_sess_state_e state_q;
	fix_pkg::fix_reply_req_t  req_q;
	logic [7:0]               msg_type_q;	// tag 35 of current msg
	logic [9:0]               seq_in_q;		// tag 34, binary
	logic [63:0]              sender_q;		// tag 49
	logic [3:0]               sender_len_q;
	logic [63:0]              target_q;		// peer id captured at logon
	logic [3:0]               target_len_q;
	logic [9:0]               exp_seq_q;	// next expected inbound
	logic [9:0]               out_seq_q;	// next outbound
	logic [HB_W-1:0]          hb_cnt_q;
	logic                     msg_done;
	logic                     hb_fire;
	logic                     req_free;
	logic                     issue;
	logic                     load;
	logic                     accept;
	logic                     go_up;
	logic                     go_down;
	logic [7:0]               rep_type;

	// ascii decimal value bytes to binary
	function automatic logic [9:0] dec_to_bin(input logic [63:0] v, input logic [3:0] len);
		logic [9:0] acc;
		acc = '0;
		for (int i = 0; i < fix_pkg::MAX_VALUE_BYTES; i++) begin
			if (i < len) begin
				acc = acc * 10'd10 + {6'b0, v[59 - 8*i -: 4]};	// low nibble of the digit
			end
		end
		return acc;
	endfunction

	assign msg_done     = field_i.valid && field_i.is_last && field_i.csum_ok;
	assign hb_fire      = (state_q == fix_pkg::LOGGED_ON) && (hb_cnt_q >= HB_W'(HB_INTERVAL));
	assign req_free     = !req_q.valid || req_ready_i;	// slot empty or leaving now
	assign load         = issue && req_free;
	assign req_o        = req_q;
	assign session_up_o = (state_q == fix_pkg::LOGGED_ON);

	always_comb begin
		issue    = 1'b0;
		accept   = 1'b0;
		go_up    = 1'b0;
		go_down  = 1'b0;
		rep_type = fix_pkg::MSG_HEARTBEAT;
		if (msg_done) begin
			if (state_q == fix_pkg::DISCONNECTED) begin
				if (msg_type_q == fix_pkg::MSG_LOGON) begin
					go_up    = 1'b1;
					issue    = 1'b1;
					accept   = 1'b1;
					rep_type = fix_pkg::MSG_LOGON;
				end	// anything else ignored
			end else if (seq_in_q != exp_seq_q) begin
				go_down  = 1'b1;	// gap, drop the session
				issue    = 1'b1;
				rep_type = fix_pkg::MSG_LOGOUT;
			end else begin
				accept = 1'b1;
				case (msg_type_q)
					fix_pkg::MSG_TEST_REQ: issue = 1'b1;	// answered by heartbeat
					fix_pkg::MSG_LOGOUT: begin
						go_down  = 1'b1;
						issue    = 1'b1;
						rep_type = fix_pkg::MSG_LOGOUT;
					end
					default: ;	// heartbeat, no reply
				endcase
			end
		end else if (hb_fire) begin
			issue = 1'b1;	// idle too long
		end
	end

	// per-field capture, payload only
	always_ff @(posedge clk) begin
		if (field_i.valid) begin
			case (field_i.tag)
				fix_pkg::TAG_SEQ: seq_in_q <= dec_to_bin(field_i.value, field_i.value_len);
				fix_pkg::TAG_SENDER: begin
					sender_q     <= field_i.value;
					sender_len_q <= (field_i.value_len > 4'd8) ? 4'd8 : field_i.value_len;
				end
				default: ;
			endcase
		end
		if (go_up) begin
			target_q     <= sender_q;
			target_len_q <= sender_len_q;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= fix_pkg::DISCONNECTED;
			req_q      <= '0;
			msg_type_q <= '0;
			exp_seq_q  <= '0;
			out_seq_q  <= 10'd1;
			hb_cnt_q   <= '0;
		end else begin
			if (field_i.valid && field_i.tag == fix_pkg::TAG_BEGIN) begin
				msg_type_q <= '0;	// forget last message type
			end else if (field_i.valid && field_i.tag == fix_pkg::TAG_TYPE) begin
				msg_type_q <= field_i.value[63:56];
			end
			if (go_up) begin
				state_q   <= fix_pkg::LOGGED_ON;
				exp_seq_q <= seq_in_q + 10'd1;
			end else if (go_down) begin
				state_q <= fix_pkg::DISCONNECTED;
			end else if (accept) begin
				exp_seq_q <= exp_seq_q + 10'd1;
			end
			if (go_down) begin
				out_seq_q <= 10'd1;	// logout carries old value first
			end else if (load) begin
				out_seq_q <= out_seq_q + 10'd1;
			end
			if (state_q != fix_pkg::LOGGED_ON || accept || load) begin
				hb_cnt_q <= '0;
			end else if (!hb_fire) begin
				hb_cnt_q <= hb_cnt_q + 1'b1;
			end
			if (load) begin
				req_q.msg_type   <= rep_type;
				req_q.seq_num    <= out_seq_q;
				req_q.target_id  <= go_up ? sender_q : target_q;
				req_q.target_len <= go_up ? sender_len_q : target_len_q;
				req_q.valid      <= 1'b1;
			end else if (req_ready_i) begin
				req_q.valid <= 1'b0;	// taken by builder
			end
		end
	end

	// held request must not move until the builder takes it
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_o.valid && !req_ready_i |=> req_o.valid && $stable(req_o));

	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
		state_q inside {fix_pkg::DISCONNECTED, fix_pkg::LOGGED_ON});

endmodule

// ==== fix_reply/fix_reply_builder.sv ====
// --------------------------------------------------------------------------
// no BodyLength or SendingTime, sender id ends at its first zero byte
// one reply at a time, byte and index hold while the FIFO reports full
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fix_reply_builder (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  fix_pkg::fix_reply_req_t req_i,
	output logic                    req_ready_o,
	input  logic [63:0]             sender_comp_id_i,
	input  logic                    tx_full_i,
	output logic [7:0]              tx_byte_o,
	output logic                    tx_write_o,
	output logic                    tx_last_o
);

	localparam logic [2:0]  F_BEGIN  = 3'd0;
	localparam logic [2:0]  F_TYPE   = 3'd1;
	localparam logic [2:0]  F_SEQ    = 3'd2;
	localparam logic [2:0]  F_SENDER = 3'd3;
	localparam logic [2:0]  F_TARGET = 3'd4;
	localparam logic [2:0]  F_CSUM   = 3'd5;
	localparam logic [63:0] BEGIN_STR = {"FIX.4.2", 8'h00};

	logic        busy_q;
	logic        ready_q;
	logic [2:0]  fidx_q;		// field in the layout
	logic [3:0]  bidx_q;		// byte within field
	logic [7:0]  sum_q;		// checksum of bytes written
	logic [7:0]  rq_type_q;
	logic [9:0]  rq_seq_q;
	logic [63:0] rq_tgt_q;
	logic [3:0]  rq_tlen_q;
	logic [3:0]  snd_len;
	logic [13:0] tag_num;
	logic [23:0] tag_txt;
	logic [3:0]  tlen;		// tag digits, 1 or 2
	logic [63:0] val;
	logic [3:0]  vlen;
	logic [3:0]  vpos;
	logic        field_end;
	logic [7:0]  cur_byte;

	always_comb begin
		snd_len = 4'd8;
		for (int k = 7; k >= 0; k--) begin
			if (sender_comp_id_i[63 - 8*k -: 8] == 8'h00) snd_len = 4'(k);	// first zero wins
		end
	end

	always_comb begin
		tag_num = fix_pkg::TAG_BEGIN;
		val     = BEGIN_STR;
		vlen    = 4'd7;
		case (fidx_q)
			F_TYPE: begin
				tag_num = fix_pkg::TAG_TYPE;
				val     = {rq_type_q, 56'b0};
				vlen    = 4'd1;
			end
			F_SEQ: begin
				tag_num = fix_pkg::TAG_SEQ;
				val     = {fix_pkg::to_dec3({4'b0, rq_seq_q}), 40'b0};	// zero padded
				vlen    = 4'd3;
			end
			F_SENDER: begin
				tag_num = fix_pkg::TAG_SENDER;
				val     = sender_comp_id_i;
				vlen    = snd_len;
			end
			F_TARGET: begin
				tag_num = fix_pkg::TAG_TARGET;
				val     = rq_tgt_q;
				vlen    = rq_tlen_q;
			end
			F_CSUM: begin
				tag_num = fix_pkg::TAG_CSUM;
				val     = {fix_pkg::to_dec3({6'b0, sum_q}), 40'b0};
				vlen    = 4'd3;
			end
			default: ;
		endcase
		tag_txt   = fix_pkg::to_dec3(tag_num);
		tlen      = (tag_num < 14'd10) ? 4'd1 : 4'd2;
		vpos      = bidx_q - tlen - 4'd1;
		field_end = (bidx_q == tlen + vlen + 4'd1);
		if (bidx_q < tlen) begin
			cur_byte = tag_txt[8*(tlen - 4'd1 - bidx_q) +: 8];	// low digits of to_dec3
		end else if (bidx_q == tlen) begin
			cur_byte = fix_pkg::ASCII_EQ;
		end else if (field_end) begin
			cur_byte = fix_pkg::SOH;
		end else begin
			cur_byte = val[63 - 8*vpos -: 8];
		end
	end

	assign req_ready_o = ready_q;
	assign tx_byte_o   = cur_byte;
	assign tx_write_o  = busy_q && !tx_full_i;
	assign tx_last_o   = tx_write_o && (fidx_q == F_CSUM) && field_end;

	always_ff @(posedge clk) begin
		if (!busy_q && ready_q && req_i.valid) begin
			rq_type_q <= req_i.msg_type;
			rq_seq_q  <= req_i.seq_num;
			rq_tgt_q  <= req_i.target_id;
			rq_tlen_q <= req_i.target_len;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			ready_q <= 1'b0;
			fidx_q  <= F_BEGIN;
			bidx_q  <= '0;
			sum_q   <= '0;
		end else if (!busy_q) begin
			if (ready_q && req_i.valid) begin
				busy_q  <= 1'b1;	// first byte next cycle
				ready_q <= 1'b0;
				fidx_q  <= F_BEGIN;
				bidx_q  <= '0;
				sum_q   <= '0;
			end else begin
				ready_q <= 1'b1;
			end
		end else if (!tx_full_i) begin
			if (fidx_q != F_CSUM) sum_q <= sum_q + cur_byte;
			if (field_end) begin
				bidx_q <= '0;
				if (fidx_q == F_CSUM) begin
					busy_q  <= 1'b0;	// reply done
					ready_q <= 1'b1;
				end else begin
					fidx_q <= fidx_q + 3'd1;
				end
			end else begin
				bidx_q <= bidx_q + 4'd1;
			end
		end
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		tx_full_i |-> !tx_write_o);

	// a blocked byte is presented again unchanged
	a_hold_on_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		busy_q && tx_full_i |=> busy_q && $stable(tx_byte_o));

endmodule

// ==== design/fix_engine.sv ====
// --------------------------------------------------------------------------
// one host, administrative messages only, tx_write only while FIFO not full
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fix_engine #(
	parameter int unsigned HB_INTERVAL = 1000	// heartbeat period in cycles
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [7:0]  rx_byte_i,		// from toe
	input  logic        rx_valid_i,
	input  logic [63:0] sender_comp_id_i,	// from app
	input  logic        tx_full_i,		// from fifo
	output logic [7:0]  tx_byte_o,		// to fifo
	output logic        tx_write_o,
	output logic        tx_last_o,
	output logic        session_up_o
);

	fix_pkg::fix_field_t     field;		// decoder -> session
	fix_pkg::fix_reply_req_t req;		// session -> builder
	logic                    req_ready;

	fix_field_decoder i_fix_field_decoder (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rx_byte_i  (rx_byte_i),
		.rx_valid_i (rx_valid_i),
		.field_o    (field)
	);

	fix_session_ctrl #(
		.HB_INTERVAL (HB_INTERVAL)
	) i_fix_session_ctrl (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.field_i      (field),
		.req_o        (req),
		.req_ready_i  (req_ready),
		.session_up_o (session_up_o)
	);

	fix_reply_builder i_fix_reply_builder (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.req_i            (req),
		.req_ready_o      (req_ready),
		.sender_comp_id_i (sender_comp_id_i),
		.tx_full_i        (tx_full_i),
		.tx_byte_o        (tx_byte_o),
		.tx_write_o       (tx_write_o),
		.tx_last_o        (tx_last_o)
	);

endmodule

// ==== test/fix_tb_stim.svh ====
// --------------------------------------------------------------------------
// rows run in order, each one starts from the session state of the last one
// '|' stands for SOH, tag 10 is appended by the testbench from the body
// --------------------------------------------------------------------------
`ifndef FIX_TB_STIM_SVH
`define FIX_TB_STIM_SVH

localparam int NUM_ROWS = 10;

string      row_name   [NUM_ROWS];	// test name
string      row_body   [NUM_ROWS];	// inbound msg up to tag 10, empty means idle
logic [7:0] row_delta  [NUM_ROWS];	// added to the true checksum, 0 when good
logic [7:0] row_type   [NUM_ROWS];	// expected reply type, 0 for none
int         row_seq    [NUM_ROWS];	// expected reply tag 34
string      row_target [NUM_ROWS];	// expected reply tag 56
logic       row_up     [NUM_ROWS];	// session_up after the row

task automatic set_row(input int r, input string name, input string body,
		input logic [7:0] delta, input logic [7:0] typ, input int seq,
		input string tgt, input logic up);
	row_name[r]   = name;
	row_body[r]   = body;
	row_delta[r]  = delta;
	row_type[r]   = typ;
	row_seq[r]    = seq;
	row_target[r] = tgt;
	row_up[r]     = up;
endtask

task automatic fill_table();
	set_row(0, "logon", "8=FIX.4.2|35=A|34=1|49=CL|56=EN|", 8'd0, "A", 1, "CL", 1'b1);
	set_row(1, "test_req", "8=FIX.4.2|35=1|34=2|49=CL|56=EN|", 8'd0, "0", 2, "CL", 1'b1);
	set_row(2, "hb_in", "8=FIX.4.2|35=0|34=3|49=CL|56=EN|", 8'd0, 8'h00, 0, "", 1'b1);
	set_row(3, "bad_csum", "8=FIX.4.2|35=1|34=4|49=CL|56=EN|", 8'd1, 8'h00, 0, "", 1'b1);
	// same seq again, nothing moved on the bad one
	set_row(4, "after_bad", "8=FIX.4.2|35=1|34=4|49=CL|56=EN|", 8'd0, "0", 3, "CL", 1'b1);
	set_row(5, "idle_hb", "", 8'd0, "0", 4, "CL", 1'b1);
	set_row(6, "seq_gap", "8=FIX.4.2|35=1|34=9|49=CL|56=EN|", 8'd0, "5", 5, "CL", 1'b0);
	set_row(7, "ignored", "8=FIX.4.2|35=1|34=6|49=CL|56=EN|", 8'd0, 8'h00, 0, "", 1'b0);
	set_row(8, "relogon", "8=FIX.4.2|35=A|34=1|49=PEER|56=EN|", 8'd0, "A", 1, "PEER", 1'b1);
	set_row(9, "logout", "8=FIX.4.2|35=5|34=2|49=PEER|56=EN|", 8'd0, "5", 2, "PEER", 1'b0);
endtask

`endif

// ==== test/fix_engine_tb.sv ====
// --------------------------------------------------------------------------
// tx FIFO modelled as taking every byte written while not full
// row spacing assumes HB_INTERVAL 200, silent rows are watched for 40 cycles
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fix_engine_tb;

	localparam int HB_INTERVAL   = 200;
	localparam int REPLY_TIMEOUT = 600;	// long enough for an idle heartbeat
	localparam int QUIET_CYCLES  = 40;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [7:0]  rx_byte;
	logic        rx_valid;
	logic [63:0] sender_id;
	logic        tx_full = 1'b0;
	logic [7:0]  tx_byte;
	logic        tx_write;
	logic        tx_last;
	logic        session_up;

	string       sender_txt = "ENGINE";
	logic [31:0] lfsr_state = 32'h6880;
	logic [7:0]  reply_bytes[$];	// bytes taken by the FIFO model
	int          last_cnt  = 0;	// replies closed by tx_last
	int          last_len  = 0;	// length at the last tx_last
	int          byte_errs = 0;
	int          len_errs  = 0;
	int          sess_errs = 0;
	int          timeouts  = 0;
	bit          ok;
	bit          stop;

	`include "fix_tb_stim.svh"

	fix_engine #(
		.HB_INTERVAL (HB_INTERVAL)
	) i_fix_engine (
		.clk              (clk),
		.rst_n_i          (rst_n),
		.rx_byte_i        (rx_byte),
		.rx_valid_i       (rx_valid),
		.sender_comp_id_i (sender_id),
		.tx_full_i        (tx_full),
		.tx_byte_o        (tx_byte),
		.tx_write_o       (tx_write),
		.tx_last_o        (tx_last),
		.session_up_o     (session_up)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, output taken from the top bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// full about a quarter of the time, two bits per cycle
	always @(negedge clk) begin : gen_full
		logic b0;
		logic b1;
		b0         = lfsr_state[31];
		lfsr_state = lfsr_step(lfsr_state);
		b1         = lfsr_state[31];
		lfsr_state = lfsr_step(lfsr_state);
		tx_full    = b0 & b1;
	end

	always @(posedge clk) begin
		if (tx_write) begin
			reply_bytes.push_back(tx_byte);
			if (tx_last) begin
				last_len = reply_bytes.size();
				last_cnt = last_cnt + 1;
			end
		end
	end

	function automatic logic [63:0] pack_id(input string s);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < s.len() && i < 8; i++) begin
			v[63 - 8*i -: 8] = s[i];	// left aligned, zero filled
		end
		return v;
	endfunction

	function automatic string to_wire(input string s);
		string w;
		w = s;
		for (int i = 0; i < w.len(); i++) begin
			if (w[i] == "|") w.putc(i, 8'h01);
		end
		return w;
	endfunction

	function automatic logic [7:0] wire_sum(input string w);
		logic [7:0] sum;
		sum = '0;
		for (int i = 0; i < w.len(); i++) begin
			sum = sum + w[i];	// mod 256
		end
		return sum;
	endfunction

	// appends tag 10 over every byte up to the closing SOH
	function automatic string close_msg(input string body, input logic [7:0] delta);
		logic [7:0] sum;
		sum = wire_sum(to_wire(body)) + delta;
		return to_wire({body, $sformatf("10=%03d|", sum)});
	endfunction

	function automatic string expect_reply(input logic [7:0] typ, input int seq,
			input string tgt);
		return close_msg($sformatf("8=FIX.4.2|35=%c|34=%03d|49=%s|56=%s|",
			typ, seq, sender_txt, tgt), 8'd0);
	endfunction

	task automatic check_byte(input string name, input int idx, input logic [7:0] exp,
			input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s byte %0d: expected %02h, actual %02h", name, idx, exp, act);
			byte_errs++;
		end
	endtask

	task automatic check_session(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s session_up: expected %b, actual %b", name, exp, act);
			sess_errs++;
		end
	endtask

	task automatic check_last(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s reply length: expected %0d, actual %0d", name, exp, act);
			len_errs++;
		end
	endtask

	task automatic send_msg(input string w);
		for (int i = 0; i < w.len(); i++) begin
			@(negedge clk);
			rx_byte  = w[i];
			rx_valid = 1'b1;
		end
		@(negedge clk);
		rx_valid = 1'b0;
		rx_byte  = 8'h00;
	endtask

	task automatic wait_reply(input int base, output bit done);
		done = 1'b0;
		for (int n = 0; n < REPLY_TIMEOUT && !done; n++) begin
			@(negedge clk);
			if (last_cnt != base) done = 1'b1;
		end
	endtask

	task automatic wait_quiet();
		for (int n = 0; n < QUIET_CYCLES && reply_bytes.size() == 0; n++) begin
			@(negedge clk);
		end
	endtask

	task automatic run_row(input int r, output bit done);
		string exp_w;
		int    base;
		done = 1'b1;
		reply_bytes.delete();
		base = last_cnt;
		if (row_body[r] != "") send_msg(close_msg(row_body[r], row_delta[r]));
		if (row_type[r] != 8'h00) begin
			wait_reply(base, done);
			if (!done) begin
				$display("no reply for %s within %0d cycles", row_name[r], REPLY_TIMEOUT);
				timeouts++;
			end else begin
				exp_w = expect_reply(row_type[r], row_seq[r], row_target[r]);
				check_last(row_name[r], exp_w.len(), last_len);
				for (int i = 0; i < exp_w.len() && i < reply_bytes.size(); i++) begin
					check_byte(row_name[r], i, exp_w[i], reply_bytes[i]);
				end
			end
		end else begin
			wait_quiet();
			check_last(row_name[r], 0, reply_bytes.size());	// any write is unexpected
		end
		check_session(row_name[r], row_up[r], session_up);
	endtask

	initial begin
		rst_n     = 1'b0;
		rx_byte   = 8'h00;
		rx_valid  = 1'b0;
		sender_id = pack_id(sender_txt);
		stop      = 1'b0;
		fill_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		for (int r = 0; r < NUM_ROWS && !stop; r++) begin
			run_row(r, ok);
			stop = !ok;	// later rows depend on this one
		end
		$display("errors: byte %0d, length %0d, session %0d, timeout %0d",
			byte_errs, len_errs, sess_errs, timeouts);
		if (byte_errs + len_errs + sess_errs + timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+test
common/fix_pkg.sv
fix_decode/fix_field_decoder.sv
fix_session/fix_session_ctrl.sv
fix_reply/fix_reply_builder.sv
design/fix_engine.sv
test/fix_engine_tb.sv

// ==== Bender.yml ====
package:
  name: fix_engine

sources:
  - common/fix_pkg.sv
  - fix_decode/fix_field_decoder.sv
  - fix_session/fix_session_ctrl.sv
  - fix_reply/fix_reply_builder.sv
  - design/fix_engine.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/fix_engine_tb.sv
